// File: cache_pkg.sv
// Cache subsystem shared types
`default_nettype none

package cache_pkg;

    // Geometry
    localparam int S_OFFSET = 5;
    localparam int S_INDEX  = 3;
    localparam int S_TAG    = 24;
    localparam int NUM_SETS = 8;
    localparam int NUM_WAYS = 2;
    localparam int S_LINE   = 256;
    localparam int S_MASK   = 32;

    typedef logic [31:0]       addr_t;
    typedef logic [S_LINE-1:0] line_t;
    typedef logic [S_MASK-1:0] mask_t;
    typedef logic [S_TAG-1:0]  tag_t;
    typedef logic [S_INDEX-1:0] index_t;
    typedef logic              way_t;
    typedef logic              port_t;

    // Datapath selects
    typedef enum logic {
        CPU_DATA,
        RAM_DATA
    } write_data_sel_t;

    typedef enum logic [1:0] {
        ALL_DIS,
        ALL_EN,
        CPU_EN
    } write_en_sel_t;

    typedef enum logic {
        CPU_ADDR,
        TAG_ADDR
    } ram_addr_sel_t;

    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        WRITEBACK,
        FILL,
        REREAD
    } cache_state_t;

    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        line_t wdata;
        mask_t byte_enable;
    } cpu_req_t;

    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        line_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: cache_datapath.sv
// Two-way cache datapath
`timescale 1ns/1ps
`default_nettype none

module cache_datapath (
    input  logic                        clk,
    input  logic                        rst_n,
    input  cache_pkg::cpu_req_t         req,
    input  logic                        load,
    input  logic                        lru_load,
    input  logic                        valid_in,
    input  logic                        dirty_in,
    input  cache_pkg::write_data_sel_t  write_data_sel,
    input  cache_pkg::write_en_sel_t    write_en_sel,
    input  cache_pkg::ram_addr_sel_t    ram_addr_sel,
    input  cache_pkg::line_t            ram_line,
    output cache_pkg::line_t            rdata,
    output logic                        hit,
    output logic                        dirty,
    output cache_pkg::way_t             lru_way,
    output cache_pkg::addr_t            mem_addr,
    output cache_pkg::line_t            mem_wdata
);

    // Storage arrays
    logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] valid_mem;
    logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] dirty_mem;
    logic [cache_pkg::NUM_SETS-1:0] lru_mem;
    cache_pkg::tag_t  tag_mem  [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
    cache_pkg::line_t data_mem [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

    // Registered array outputs and request
    cache_pkg::cpu_req_t req_q;
    logic [cache_pkg::NUM_WAYS-1:0] valid_q;
    logic [cache_pkg::NUM_WAYS-1:0] dirty_q;
    cache_pkg::tag_t  tag_q  [cache_pkg::NUM_WAYS];
    cache_pkg::line_t data_q [cache_pkg::NUM_WAYS];

    logic                           rd_en;
    cache_pkg::index_t              rindex;
    cache_pkg::index_t              windex;
    cache_pkg::tag_t                wtag;
    logic [cache_pkg::NUM_WAYS-1:0] hit_vec;
    cache_pkg::way_t                hit_way;
    cache_pkg::way_t                sel_way;
    cache_pkg::mask_t               write_en;
    cache_pkg::line_t               write_data;

    assign rd_en  = req.read | req.write;
    assign rindex = req.address[cache_pkg::S_OFFSET +: cache_pkg::S_INDEX];
    assign windex = req_q.address[cache_pkg::S_OFFSET +: cache_pkg::S_INDEX];
    assign wtag   = req_q.address[cache_pkg::S_OFFSET + cache_pkg::S_INDEX +: cache_pkg::S_TAG];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_way <= '0;
        end else if (rd_en) begin
            for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
                valid_q[w] <= valid_mem[w][rindex];
                dirty_q[w] <= dirty_mem[w][rindex];
            end
            lru_way <= lru_mem[rindex];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            req_q <= req;
            for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
                tag_q[w]  <= tag_mem[w][rindex];
                data_q[w] <= data_mem[w][rindex];
            end
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[w] && (tag_q[w] == wtag);
            if (hit_vec[w])
                hit_way = cache_pkg::way_t'(w);
        end
    end

    assign hit     = |hit_vec;
    assign sel_way = hit ? hit_way : lru_way;
    assign dirty   = dirty_q[lru_way];

    always_comb begin
        case (write_en_sel)
            cache_pkg::ALL_EN: write_en = '1;
            cache_pkg::CPU_EN: write_en = req_q.byte_enable;
            default:           write_en = '0;
        endcase
    end

    assign write_data = (write_data_sel == cache_pkg::RAM_DATA) ? ram_line : req_q.wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_mem <= '0;
            dirty_mem <= '0;
            lru_mem   <= '0;
        end else begin
            if (load) begin
                valid_mem[sel_way][windex] <= valid_in;
                dirty_mem[sel_way][windex] <= dirty_in;
            end
            // LRU points at the way not just used
            if (lru_load)
                lru_mem[windex] <= ~hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            tag_mem[sel_way][windex] <= wtag;
        for (int b = 0; b < cache_pkg::S_MASK; b++) begin
            if (load && write_en[b])
                data_mem[sel_way][windex][8*b +: 8] <= write_data[8*b +: 8];
        end
    end

    always_comb begin
        case (ram_addr_sel)
            cache_pkg::TAG_ADDR:
                mem_addr = {tag_q[lru_way], windex, {cache_pkg::S_OFFSET{1'b0}}};
            default:
                mem_addr = {req_q.address[31:cache_pkg::S_OFFSET], {cache_pkg::S_OFFSET{1'b0}}};
        endcase
    end

    assign rdata     = data_q[hit_way];
    assign mem_wdata = data_q[lru_way];

    // A tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit_vec));

endmodule

`default_nettype wire

// File: cache_control.sv
// Cache controller FSM
`timescale 1ns/1ps
`default_nettype none

module cache_control (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        read,
    input  logic                        write,
    input  logic                        hit,
    input  logic                        dirty,
    input  logic                        pmem_resp,
    output logic                        mem_resp,
    output logic                        pmem_read,
    output logic                        pmem_write,
    output logic                        load,
    output logic                        lru_load,
    output logic                        valid_in,
    output logic                        dirty_in,
    output cache_pkg::write_data_sel_t  write_data_sel,
    output cache_pkg::write_en_sel_t    write_en_sel,
    output cache_pkg::ram_addr_sel_t    ram_addr_sel
);

    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= cache_pkg::IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state     = state;
        mem_resp       = 1'b0;
        pmem_read      = 1'b0;
        pmem_write     = 1'b0;
        load           = 1'b0;
        lru_load       = 1'b0;
        valid_in       = 1'b0;
        dirty_in       = 1'b0;
        write_data_sel = cache_pkg::CPU_DATA;
        write_en_sel   = cache_pkg::ALL_DIS;
        ram_addr_sel   = cache_pkg::CPU_ADDR;
        case (state)
            cache_pkg::IDLE: begin
                if (read || write)
                    next_state = cache_pkg::CHECK;
            end
            cache_pkg::CHECK: begin
                if (hit) begin
                    mem_resp   = 1'b1;
                    lru_load   = 1'b1;
                    next_state = cache_pkg::IDLE;
                    // Merge CPU bytes and mark the line dirty
                    if (write) begin
                        load         = 1'b1;
                        valid_in     = 1'b1;
                        dirty_in     = 1'b1;
                        write_en_sel = cache_pkg::CPU_EN;
                    end
                end else if (dirty) begin
                    next_state = cache_pkg::WRITEBACK;
                end else begin
                    next_state = cache_pkg::FILL;
                end
            end
            cache_pkg::WRITEBACK: begin
                pmem_write   = 1'b1;
                ram_addr_sel = cache_pkg::TAG_ADDR;
                if (pmem_resp)
                    next_state = cache_pkg::FILL;
            end
            cache_pkg::FILL: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    load           = 1'b1;
                    valid_in       = 1'b1;
                    write_data_sel = cache_pkg::RAM_DATA;
                    write_en_sel   = cache_pkg::ALL_EN;
                    next_state     = cache_pkg::REREAD;
                end
            end
            // Let the registered arrays pick up the new line
            cache_pkg::REREAD: next_state = cache_pkg::CHECK;
            default:           next_state = cache_pkg::IDLE;
        endcase
    end

    // Response only while the CPU still holds its request
    assert property (@(posedge clk) disable iff (!rst_n) mem_resp |-> (read || write));

endmodule

`default_nettype wire

// File: mem_arbiter.sv
// Round-robin memory port arbiter
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::mem_req_t req0,
    input  cache_pkg::mem_req_t req1,
    input  logic                pmem_resp,
    input  cache_pkg::line_t    pmem_rdata,
    output cache_pkg::mem_req_t pmem_req,
    output logic                resp0,
    output logic                resp1,
    output cache_pkg::line_t    rdata
);

    logic            want0;
    logic            want1;
    logic            active;
    logic            locked;
    cache_pkg::port_t grant;
    cache_pkg::port_t grant_q;
    cache_pkg::port_t last_q;

    assign want0 = req0.read | req0.write;
    assign want1 = req1.read | req1.write;

    // Free port grants at once, ties go away from the last served
    always_comb begin
        if (locked)
            grant = grant_q;
        else if (want0 && want1)
            grant = ~last_q;
        else if (want1)
            grant = 1'b1;
        else
            grant = 1'b0;
    end

    assign active = grant ? want1 : want0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked  <= 1'b0;
            grant_q <= 1'b0;
            last_q  <= 1'b1;
        end else if (pmem_resp) begin
            locked <= 1'b0;
            last_q <= grant;
        end else if (active && !locked) begin
            locked  <= 1'b1;
            grant_q <= grant;
        end
    end

    assign pmem_req = grant ? req1 : req0;
    assign resp0    = pmem_resp & ~grant;
    assign resp1    = pmem_resp & grant;
    assign rdata    = pmem_rdata;

    // Memory answers only the locked port while it still holds its request
    assert property (@(posedge clk) disable iff (!rst_n)
        pmem_resp |-> locked && (grant_q ? want1 : want0));

endmodule

`default_nettype wire

// File: cache_system.sv
// Dual cache memory subsystem
`timescale 1ns/1ps
`default_nettype none

module cache_system (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::cpu_req_t cpu0_req,
    input  cache_pkg::cpu_req_t cpu1_req,
    input  logic                pmem_resp,
    input  cache_pkg::line_t    pmem_rdata,
    output cache_pkg::line_t    cpu0_rdata,
    output cache_pkg::line_t    cpu1_rdata,
    output logic                cpu0_resp,
    output logic                cpu1_resp,
    output cache_pkg::mem_req_t pmem_req
);

    cache_pkg::cpu_req_t cpu_req   [2];
    cache_pkg::line_t    cpu_rdata [2];
    cache_pkg::mem_req_t mem_req   [2];
    logic [1:0]          cpu_resp;
    logic [1:0]          port_resp;
    cache_pkg::line_t    ram_line;

    assign cpu_req[0] = cpu0_req;
    assign cpu_req[1] = cpu1_req;
    assign cpu0_rdata = cpu_rdata[0];
    assign cpu1_rdata = cpu_rdata[1];
    assign cpu0_resp  = cpu_resp[0];
    assign cpu1_resp  = cpu_resp[1];

    for (genvar c = 0; c < 2; c++) begin : g_cache
        logic                       load;
        logic                       lru_load;
        logic                       valid_in;
        logic                       dirty_in;
        logic                       hit;
        logic                       dirty;
        logic                       pmem_read;
        logic                       pmem_write;
        cache_pkg::write_data_sel_t write_data_sel;
        cache_pkg::write_en_sel_t   write_en_sel;
        cache_pkg::ram_addr_sel_t   ram_addr_sel;
        cache_pkg::addr_t           mem_addr;
        cache_pkg::line_t           mem_wdata;

        assign mem_req[c] = '{read: pmem_read, write: pmem_write,
                              address: mem_addr, wdata: mem_wdata};

        cache_datapath u_datapath (
            .clk            (clk),
            .rst_n          (rst_n),
            .req            (cpu_req[c]),
            .load           (load),
            .lru_load       (lru_load),
            .valid_in       (valid_in),
            .dirty_in       (dirty_in),
            .write_data_sel (write_data_sel),
            .write_en_sel   (write_en_sel),
            .ram_addr_sel   (ram_addr_sel),
            .ram_line       (ram_line),
            .rdata          (cpu_rdata[c]),
            .hit            (hit),
            .dirty          (dirty),
            .lru_way        (),
            .mem_addr       (mem_addr),
            .mem_wdata      (mem_wdata)
        );

        cache_control u_control (
            .clk            (clk),
            .rst_n          (rst_n),
            .read           (cpu_req[c].read),
            .write          (cpu_req[c].write),
            .hit            (hit),
            .dirty          (dirty),
            .pmem_resp      (port_resp[c]),
            .mem_resp       (cpu_resp[c]),
            .pmem_read      (pmem_read),
            .pmem_write     (pmem_write),
            .load           (load),
            .lru_load       (lru_load),
            .valid_in       (valid_in),
            .dirty_in       (dirty_in),
            .write_data_sel (write_data_sel),
            .write_en_sel   (write_en_sel),
            .ram_addr_sel   (ram_addr_sel)
        );
    end

    mem_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .req0       (mem_req[0]),
        .req1       (mem_req[1]),
        .pmem_resp  (pmem_resp),
        .pmem_rdata (pmem_rdata),
        .pmem_req   (pmem_req),
        .resp0      (port_resp[0]),
        .resp1      (port_resp[1]),
        .rdata      (ram_line)
    );

endmodule

`default_nettype wire

// File: cache_checker.sv
// Cache system scoreboard
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::cpu_req_t cpu0_req,
    input  cache_pkg::cpu_req_t cpu1_req,
    input  cache_pkg::line_t    cpu0_rdata,
    input  cache_pkg::line_t    cpu1_rdata,
    input  logic                cpu0_resp,
    input  logic                cpu1_resp,
    input  cache_pkg::mem_req_t pmem_req,
    input  logic                pmem_resp,
    input  cache_pkg::line_t    pmem_rdata,
    output int                  errors,
    output int                  pmem_reads,
    output int                  pmem_writes
);

    // Latest CPU-visible contents per line address
    cache_pkg::line_t shadow [cache_pkg::addr_t];
    logic [1:0]       active;

    function automatic cache_pkg::line_t merge_line(input cache_pkg::line_t old,
                                                    input cache_pkg::line_t wdata,
                                                    input cache_pkg::mask_t mask);
        cache_pkg::line_t res;
        res = old;
        for (int b = 0; b < cache_pkg::S_MASK; b++) begin
            if (mask[b])
                res[8*b +: 8] = wdata[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_cpu(input int port, input cache_pkg::cpu_req_t req,
                             input cache_pkg::line_t rdata);
        cache_pkg::addr_t a;
        a = {req.address[31:cache_pkg::S_OFFSET], {cache_pkg::S_OFFSET{1'b0}}};
        if (!(req.read || req.write)) begin
            $display("Port %0d gave a response with no request pending", port);
            errors++;
        end else if (int'(a[16]) != port) begin
            $display("Port %0d served address %h outside its range", port, a);
            errors++;
        end else if (!shadow.exists(a)) begin
            $display("ERR %0t: port %0d answered line %h without a fill", $time, port, a);
            errors++;
        end else if (req.write) begin
            shadow[a] = merge_line(shadow[a], req.wdata, req.byte_enable);
        end else if (rdata !== shadow[a]) begin
            $display("ERR %0t: port %0d read %h got %h, expected %h",
                     $time, port, a, rdata, shadow[a]);
            errors++;
        end
    endtask

    task automatic check_mem();
        cache_pkg::addr_t a;
        a = pmem_req.address;
        if (pmem_req.read == pmem_req.write) begin
            $display("Memory answered a request that was not a single read or write");
            errors++;
        end else if (!active[a[16]]) begin
            $display("Memory transaction at %h belongs to no waiting port", a);
            errors++;
        end else if (pmem_req.write) begin
            pmem_writes++;
            if (!shadow.exists(a)) begin
                $display("ERR %0t: writeback to %h, a line never filled", $time, a);
                errors++;
            end else if (pmem_req.wdata !== shadow[a]) begin
                $display("ERR %0t: writeback %h got %h, expected %h",
                         $time, a, pmem_req.wdata, shadow[a]);
                errors++;
            end
        end else begin
            pmem_reads++;
            if (!shadow.exists(a))
                shadow[a] = pmem_rdata;
            else if (pmem_rdata !== shadow[a]) begin
                $display("ERR %0t: refetch of %h returned stale data", $time, a);
                errors++;
            end
        end
    endtask

    // Everything sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            errors      = 0;
            pmem_reads  = 0;
            pmem_writes = 0;
        end else begin
            active[0] = cpu0_req.read | cpu0_req.write;
            active[1] = cpu1_req.read | cpu1_req.write;
            if ((pmem_req.read || pmem_req.write) && active == 2'b00) begin
                $display("Memory request raised with no CPU request pending");
                errors++;
            end
            if (cpu0_resp)
                check_cpu(0, cpu0_req, cpu0_rdata);
            if (cpu1_resp)
                check_cpu(1, cpu1_req, cpu1_rdata);
            if (pmem_resp)
                check_mem();
        end
    end

endmodule

`default_nettype wire

// File: tb_cache_system.sv
// Cache system testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cache_system;

    localparam int TIMEOUT = 200;

    logic                clk;
    logic                rst_n;
    cache_pkg::cpu_req_t cpu0_req;
    cache_pkg::cpu_req_t cpu1_req;
    logic                pmem_resp;
    cache_pkg::line_t    pmem_rdata;
    cache_pkg::line_t    cpu0_rdata;
    cache_pkg::line_t    cpu1_rdata;
    logic                cpu0_resp;
    logic                cpu1_resp;
    cache_pkg::mem_req_t pmem_req;

    int                  chk_errors;
    int                  pmem_reads;
    int                  pmem_writes;
    int                  tb_errors;
    int                  timeouts;
    int                  base;
    logic [31:0]         seed;
    logic                mem_busy;
    int                  mem_delay;
    cache_pkg::line_t    mem [cache_pkg::addr_t];

    always #50 clk = ~clk;

    cache_system dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu0_req   (cpu0_req),
        .cpu1_req   (cpu1_req),
        .pmem_resp  (pmem_resp),
        .pmem_rdata (pmem_rdata),
        .cpu0_rdata (cpu0_rdata),
        .cpu1_rdata (cpu1_rdata),
        .cpu0_resp  (cpu0_resp),
        .cpu1_resp  (cpu1_resp),
        .pmem_req   (pmem_req)
    );

    cache_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu0_req    (cpu0_req),
        .cpu1_req    (cpu1_req),
        .cpu0_rdata  (cpu0_rdata),
        .cpu1_rdata  (cpu1_rdata),
        .cpu0_resp   (cpu0_resp),
        .cpu1_resp   (cpu1_resp),
        .pmem_req    (pmem_req),
        .pmem_resp   (pmem_resp),
        .pmem_rdata  (pmem_rdata),
        .errors      (chk_errors),
        .pmem_reads  (pmem_reads),
        .pmem_writes (pmem_writes)
    );

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_below(input int n);
        return int'((rand32() >> 16) % n);
    endfunction

    function automatic cache_pkg::line_t rand_line();
        cache_pkg::line_t l;
        for (int i = 0; i < 8; i++)
            l[32*i +: 32] = rand32();
        return l;
    endfunction

    // Power-up memory contents, hashed from the full byte address
    function automatic cache_pkg::line_t fill_line(input cache_pkg::addr_t a);
        cache_pkg::line_t l;
        for (int i = 0; i < 8; i++)
            l[32*i +: 32] = ((a + 32'(4 * i)) * 32'h9e3779b1) ^ 32'h3c5a_a5c3;
        return l;
    endfunction

    // Memory model with 1 to 6 cycles of latency
    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            mem_busy  = 1'b0;
            pmem_resp = 1'b0;
        end else if (pmem_resp) begin
            pmem_resp = 1'b0;
        end else if (!mem_busy) begin
            if (pmem_req.read || pmem_req.write) begin
                mem_busy  = 1'b1;
                mem_delay = 1 + rand_below(6);
            end
        end else if (mem_delay > 1) begin
            mem_delay--;
        end else begin
            mem_busy  = 1'b0;
            pmem_resp = 1'b1;
            if (pmem_req.write)
                mem[pmem_req.address] = pmem_req.wdata;
            else if (mem.exists(pmem_req.address))
                pmem_rdata = mem[pmem_req.address];
            else
                pmem_rdata = fill_line(pmem_req.address);
        end
    end

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic cpu_access(input int port, input logic is_write,
                              input cache_pkg::addr_t addr,
                              input cache_pkg::line_t data, input cache_pkg::mask_t mask);
        cache_pkg::cpu_req_t req;
        logic                got;
        int                  n;
        if (timeouts == 0) begin
            req = '{read: !is_write, write: is_write, address: addr,
                    wdata: data, byte_enable: mask};
            if (port == 1)
                cpu1_req = req;
            else
                cpu0_req = req;
            got = 1'b0;
            n   = 0;
            while (!got && n < TIMEOUT) begin
                @(negedge clk);
                got = (port == 1) ? cpu1_resp : cpu0_resp;
                n++;
            end
            @(posedge clk);
            #1;
            if (port == 1)
                cpu1_req = '0;
            else
                cpu0_req = '0;
            if (!got) begin
                $display("Port %0d request to %h got no response within %0d cycles",
                         port, addr, TIMEOUT);
                timeouts++;
            end
        end
    endtask

    task automatic expect_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t: %s was %0d, expected %0d", $time, what, got, exp);
            tb_errors++;
        end
    endtask

    task automatic port_traffic(input int port, input int ops);
        cache_pkg::addr_t a;
        for (int i = 0; i < ops; i++) begin
            // Four tags over all eight sets, port 1 above 64 KiB
            a = (port == 1 ? 32'h0001_0000 : 32'h0) | 32'(rand_below(4) << 8)
                | 32'(rand_below(8) << 5);
            cpu_access(port, rand_below(2) == 1, a, rand_line(), rand32());
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        cpu0_req   = '0;
        cpu1_req   = '0;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        seed       = 32'd74519;
        tb_errors  = 0;
        timeouts   = 0;
        mem_busy   = 1'b0;
        mem_delay  = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        expect_count("pmem traffic while idle", pmem_reads + pmem_writes, 0);

        cpu_access(0, 1'b0, 32'h0000_0040, '0, '0);
        base = pmem_reads + pmem_writes;
        cpu_access(0, 1'b0, 32'h0000_0040, '0, '0);
        expect_count("pmem traffic on reread", pmem_reads + pmem_writes - base, 0);

        // Masked writes on a hit and on a miss
        cpu_access(0, 1'b1, 32'h0000_0040, rand_line(), rand32());
        cpu_access(0, 1'b0, 32'h0000_0040, '0, '0);
        cpu_access(0, 1'b1, 32'h0000_0160, rand_line(), rand32());
        cpu_access(0, 1'b0, 32'h0000_0160, '0, '0);

        // Set 5 with three tags, the first one dirty
        cpu_access(0, 1'b1, 32'h0000_01a0, rand_line(), 32'hffff_0f0f);
        cpu_access(0, 1'b0, 32'h0000_02a0, '0, '0);
        base = pmem_writes;
        cpu_access(0, 1'b0, 32'h0000_03a0, '0, '0);
        expect_count("writebacks on dirty eviction", pmem_writes - base, 1);
        base = pmem_writes;
        cpu_access(0, 1'b0, 32'h0000_01a0, '0, '0);
        expect_count("writebacks on clean eviction", pmem_writes - base, 0);

        fork
            port_traffic(0, 80);
            port_traffic(1, 80);
        join
        repeat (4) @(posedge clk);
        $display("errors: checker %0d, testbench %0d, timeouts %0d",
                 chk_errors, tb_errors, timeouts);
        if (chk_errors == 0 && tb_errors == 0 && timeouts == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
cache_pkg.sv
cache_datapath.sv
cache_control.sv
mem_arbiter.sv
cache_system.sv
cache_checker.sv
tb_cache_system.sv

// File: Bender.yml
package:
  name: cache_system

sources:
  - cache_pkg.sv
  - cache_datapath.sv
  - cache_control.sv
  - mem_arbiter.sv
  - cache_system.sv
  - target: test
    files:
      - cache_checker.sv
      - tb_cache_system.sv
